//--- src/hbm_read_pkg.sv
/*
  Shared widths, types and channel structs of the HBM channel read controller.
  Imported by the RTL modules and the testbench.
*/
package hbm_read_pkg;

  ////////////////////
  // widths
  ////////////////////

  // byte address on the AXI side
  localparam int addr_width = 32;
  // one HBM word, which is one edge entry
  localparam int data_width = 32;
  // bytes per word, used to word-align the software offset
  localparam int word_bytes = data_width / 8;

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [data_width-1:0] data_t;

  ////////////////////
  // AXI channels
  ////////////////////

  // read address channel, single beat so len stays 0
  typedef struct packed {
    logic       valid;
    addr_t      addr;
    logic [7:0] len;
  } ar_req_t;

  // read data channel
  typedef struct packed {
    logic  valid;
    data_t data;
    logic  last;
  } r_beat_t;

  // edge request stage states
  typedef enum logic [1:0] {
    stage_idle    = 2'd0,
    stage_running = 2'd1
  } stage_state_t;

endpackage

//--- src/sync_fifo.sv
/*
  Synchronous first-word-fall-through FIFO on a register array.
  The head entry is always present on rd_data while empty is low.
  Holds both the edge addresses and the returned edge words.
*/
module sync_fifo #(
  parameter int width = 32,
  parameter int depth = 4
) (
  input  logic                   aclk,
  input  logic                   areset,
  input  logic                   wr_en,
  input  logic [width-1:0]       wr_data,
  input  logic                   rd_en,
  output logic [width-1:0]       rd_data,
  output logic                   empty,
  output logic                   full,
  output logic [$clog2(depth):0] count
);

  localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
  localparam int count_width = $clog2(depth) + 1;
  localparam logic [ptr_width-1:0] last_ptr = ptr_width'(depth - 1);

  logic [width-1:0] mem [depth];
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic do_write;
  logic do_read;

  // a write while full or a read while empty is simply ignored
  assign do_write = wr_en && !full;
  assign do_read = rd_en && !empty;

  ////////////////////
  // storage
  ////////////////////

  always_ff @(posedge aclk) begin
    if (do_write) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // fall-through head, no read latency
  assign rd_data = mem[rd_ptr];

  ////////////////////
  // pointers and count
  ////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap at the last slot, so any depth works
      if (do_write) begin
        wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous write and read leaves the count unchanged
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign empty = (count == '0);
  assign full = (count == count_width'(depth));

endmodule

//--- src/edge_request_stage.sv
/*
  Front end of the read controller.
  ctrl_start latches the word-aligned base offset and arms the stage. Each
  accepted edge address is offset and written into the address FIFO.
*/
module edge_request_stage import hbm_read_pkg::*; #(
  parameter int max_outstanding = 4
) (
  input  logic                             aclk,
  input  logic                             areset,
  input  logic                             ctrl_start,
  input  addr_t                            ctrl_addr_offset,
  input  addr_t                            edge_addr,
  input  logic                             edge_addr_valid,
  input  logic                             fifo_full,
  input  logic [$clog2(max_outstanding):0] fifo_count,
  output logic                             wr_en,
  output addr_t                            wr_data,
  output logic                             full,
  output logic                             stage_full
);

  localparam int count_width = $clog2(max_outstanding) + 1;
  // warning level at half of the address FIFO
  localparam logic [count_width-1:0] half_depth = count_width'(max_outstanding / 2);
  localparam logic [count_width-1:0] last_slot = count_width'(max_outstanding - 1);
  // clears the byte-within-word bits
  localparam addr_t align_mask = ~addr_t'(word_bytes - 1);

  stage_state_t state;
  addr_t offset_r;
  logic pending_fill;
  logic accept;

  ////////////////////
  // control
  ////////////////////

  // offset is captured on the same edge as ctrl_start
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      offset_r <= ctrl_addr_offset & align_mask;
    end
  end

  // idle until the first start, then stays armed
  always_ff @(posedge aclk) begin
    if (areset) begin
      state <= stage_idle;
    end else begin
      case (state)
        stage_idle:    state <= ctrl_start ? stage_running : stage_idle;
        stage_running: state <= stage_running;
        default:       state <= stage_idle;
      endcase
    end
  end

  ////////////////////
  // address path
  ////////////////////

  // the registered write not yet in the FIFO would take its last slot
  assign pending_fill = wr_en && (fifo_count == last_slot);

  // no ready on the edge side, a rejected address is lost
  assign accept = edge_addr_valid && (state == stage_running) && !fifo_full && !pending_fill;

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= accept;
    end
  end

  // sum registered here, written into the FIFO on the next edge
  always_ff @(posedge aclk) begin
    if (accept) begin
      wr_data <= offset_r + edge_addr;
    end
  end

  assign full = fifo_full;
  assign stage_full = (fifo_count >= half_depth);

endmodule

//--- src/read_addr_issuer.sv
/*
  Issues single-beat AXI4 reads from the head of the address FIFO.
  A credit counter caps the reads whose data has not yet left the controller,
  which keeps the data FIFO from overflowing with rready held high.
*/
module read_addr_issuer import hbm_read_pkg::*; #(
  parameter int max_outstanding = 4
) (
  input  logic    aclk,
  input  logic    areset,
  input  logic    fifo_empty,
  input  addr_t   fifo_head,
  output logic    fifo_pop,
  output ar_req_t m_axi_ar,
  input  logic    m_axi_arready,
  input  logic    credit_return
);

  localparam int credit_width = $clog2(max_outstanding + 1);
  localparam logic [credit_width-1:0] credit_max = credit_width'(max_outstanding);

  logic [credit_width-1:0] credit_count;
  logic ar_valid;
  logic ar_xfer;
  logic credit_free;

  assign credit_free = (credit_count != '0);
  assign ar_xfer = ar_valid && m_axi_arready;

  ////////////////////
  // AR channel
  ////////////////////

  // valid rises one cycle after a head shows up with a credit free
  // and then holds until arready
  always_ff @(posedge aclk) begin
    if (areset) begin
      ar_valid <= 1'b0;
    end else if (!ar_valid) begin
      ar_valid <= !fifo_empty && credit_free;
    end else if (m_axi_arready) begin
      ar_valid <= 1'b0;
    end
  end

  // the head does not move before the pop, so the address stays stable
  always_comb begin
    m_axi_ar.valid = ar_valid;
    m_axi_ar.addr  = fifo_head;
    m_axi_ar.len   = 8'd0;
  end

  assign fifo_pop = ar_xfer;

  ////////////////////
  // credits
  ////////////////////

  // one credit per AR transfer, returned when the word leaves on edge_data
  always_ff @(posedge aclk) begin
    if (areset) begin
      credit_count <= credit_max;
    end else begin
      case ({ar_xfer, credit_return})
        2'b10:   credit_count <= credit_count - 1'b1;
        2'b01:   credit_count <= credit_count + 1'b1;
        default: credit_count <= credit_count;
      endcase
    end
  end

endmodule

//--- src/hbm_read_top.sv
/*
  HBM channel read controller, top level.
  Edge addresses flow through the request stage and the address FIFO to the
  AR issuer; read data returns through the data FIFO to the edge_data stream.
*/
module hbm_read_top import hbm_read_pkg::*; #(
  parameter int max_outstanding = 4
) (
  input  logic    aclk,
  input  logic    areset,
  // software control
  input  logic    ctrl_start,
  input  addr_t   ctrl_addr_offset,
  // accelerator edge requests
  input  addr_t   edge_addr,
  input  logic    edge_addr_valid,
  output logic    full,
  output logic    stage_full,
  // AXI4 read master
  output ar_req_t m_axi_ar,
  input  logic    m_axi_arready,
  input  r_beat_t m_axi_r,
  output logic    m_axi_rready,
  // returned edge words
  output data_t   edge_data,
  output logic    edge_data_valid,
  input  logic    edge_data_ready
);

  localparam int count_width = $clog2(max_outstanding) + 1;

  // address path
  logic addr_wr_en;
  addr_t addr_wr_data;
  addr_t addr_head;
  logic addr_empty;
  logic addr_full;
  logic [count_width-1:0] addr_count;
  logic addr_pop;

  // data path
  logic data_wr_en;
  logic data_empty;
  logic data_pop;

  ////////////////////
  // request side
  ////////////////////

  edge_request_stage #(
    .max_outstanding (max_outstanding)
  ) u_edge_request_stage (
    .aclk             (aclk),
    .areset           (areset),
    .ctrl_start       (ctrl_start),
    .ctrl_addr_offset (ctrl_addr_offset),
    .edge_addr        (edge_addr),
    .edge_addr_valid  (edge_addr_valid),
    .fifo_full        (addr_full),
    .fifo_count       (addr_count),
    .wr_en            (addr_wr_en),
    .wr_data          (addr_wr_data),
    .full             (full),
    .stage_full       (stage_full)
  );

  sync_fifo #(
    .width (addr_width),
    .depth (max_outstanding)
  ) u_addr_fifo (
    .aclk    (aclk),
    .areset  (areset),
    .wr_en   (addr_wr_en),
    .wr_data (addr_wr_data),
    .rd_en   (addr_pop),
    .rd_data (addr_head),
    .empty   (addr_empty),
    .full    (addr_full),
    .count   (addr_count)
  );

  read_addr_issuer #(
    .max_outstanding (max_outstanding)
  ) u_read_addr_issuer (
    .aclk          (aclk),
    .areset        (areset),
    .fifo_empty    (addr_empty),
    .fifo_head     (addr_head),
    .fifo_pop      (addr_pop),
    .m_axi_ar      (m_axi_ar),
    .m_axi_arready (m_axi_arready),
    .credit_return (data_pop)
  );

  ////////////////////
  // return side
  ////////////////////

  // data FIFO holds every read in flight, so rready never has to drop
  assign m_axi_rready = ~areset;
  assign data_wr_en = m_axi_r.valid & m_axi_rready;

  sync_fifo #(
    .width (data_width),
    .depth (max_outstanding)
  ) u_data_fifo (
    .aclk    (aclk),
    .areset  (areset),
    .wr_en   (data_wr_en),
    .wr_data (m_axi_r.data),
    .rd_en   (data_pop),
    .rd_data (edge_data),
    .empty   (data_empty),
    .full    (),
    .count   ()
  );

  assign edge_data_valid = ~data_empty;
  // an output transfer also hands the credit back to the issuer
  assign data_pop = edge_data_valid & edge_data_ready;

endmodule

//--- sim/hbm_read_sva.sv
/*
  Concurrent checks on the AR channel and the read credit counter.
  Bound into every read_addr_issuer instance.
*/
module hbm_read_sva import hbm_read_pkg::*; #(
  parameter int max_outstanding = 4
) (
  input logic                                   aclk,
  input logic                                   areset,
  input ar_req_t                                m_axi_ar,
  input logic                                   m_axi_arready,
  input logic [$clog2(max_outstanding + 1)-1:0] credit_count
);

  localparam int credit_width = $clog2(max_outstanding + 1);
  localparam logic [credit_width-1:0] credit_max = credit_width'(max_outstanding);

  // failures seen so far, read back by the testbench summary
  int fail_count = 0;

  // a waiting request keeps valid and address until arready
  a_ar_stable: assert property (@(posedge aclk) disable iff (areset)
      m_axi_ar.valid && !m_axi_arready |=> m_axi_ar.valid && $stable(m_axi_ar.addr))
    else begin
      fail_count++;
      $error("AR valid dropped or address changed before arready");
    end

  // single-beat reads only
  a_ar_len: assert property (@(posedge aclk) disable iff (areset)
      m_axi_ar.valid |-> m_axi_ar.len == 8'd0)
    else begin
      fail_count++;
      $error("AR request with a burst length other than one beat");
    end

  a_credit_bound: assert property (@(posedge aclk) disable iff (areset)
      credit_count <= credit_max)
    else begin
      fail_count++;
      $error("credit counter above the outstanding read limit");
    end

endmodule

bind read_addr_issuer hbm_read_sva #(
  .max_outstanding (max_outstanding)
) u_sva (
  .aclk          (aclk),
  .areset        (areset),
  .m_axi_ar      (m_axi_ar),
  .m_axi_arready (m_axi_arready),
  .credit_count  (credit_count)
);

//--- sim/tb_hbm_read.sv
/*
  Testbench for the HBM channel read controller.
  Rows of sim/hbm_read_golden.txt give offsets, edge addresses and expected
  words; an AXI read slave model answers the reads. Run from the project root.
*/
module tb_hbm_read import hbm_read_pkg::*; ();

  localparam int max_outstanding = 4;
  localparam int max_rows = 64;
  localparam int wait_limit = 200;
  localparam int idle_window = 20;
  // expected column value of an address that has to be dropped
  localparam data_t drop_mark = 32'hffff_ffff;

  logic aclk = 1'b0;
  logic areset;
  logic ctrl_start;
  addr_t ctrl_addr_offset;
  addr_t edge_addr;
  logic edge_addr_valid;
  logic full;
  logic stage_full;
  ar_req_t m_axi_ar;
  logic m_axi_arready = 1'b0;
  r_beat_t m_axi_r = '0;
  logic m_axi_rready;
  data_t edge_data;
  logic edge_data_valid;
  logic edge_data_ready = 1'b0;

  logic [31:0] golden [0:4*max_rows-1];
  addr_t ar_q [$];
  data_t exp_q [$];
  logic [31:0] rnd_state = 32'h1cb8_a12e;
  addr_t beat_addr;
  data_t expected_word;
  int r_wait;
  int ar_count;
  int ar_base;
  int n_expected;
  int value_errors;
  int other_errors;
  int cur_code;
  string cur_name;
  logic ready_hold = 1'b0;
  logic random_timing = 1'b0;

  hbm_read_top #(
    .max_outstanding (max_outstanding)
  ) uut (
    .aclk             (aclk),
    .areset           (areset),
    .ctrl_start       (ctrl_start),
    .ctrl_addr_offset (ctrl_addr_offset),
    .edge_addr        (edge_addr),
    .edge_addr_valid  (edge_addr_valid),
    .full             (full),
    .stage_full       (stage_full),
    .m_axi_ar         (m_axi_ar),
    .m_axi_arready    (m_axi_arready),
    .m_axi_r          (m_axi_r),
    .m_axi_rready     (m_axi_rready),
    .edge_data        (edge_data),
    .edge_data_valid  (edge_data_valid),
    .edge_data_ready  (edge_data_ready)
  );

  always #5 aclk = ~aclk;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic string name_of_test(input int code);
    case (code)
      1:       return "no_start";
      2:       return "in_order";
      3:       return "backpressure";
      4:       return "stage_full";
      5:       return "random_timing";
      default: return "unknown";
    endcase
  endfunction

  ////////////////////
  // AXI slave and output checker
  ////////////////////

  // everything here looks at values stable since the last rising edge
  always @(negedge aclk) begin
    // ready seen by the coming rising edge
    edge_data_ready = !ready_hold;
    // word leaves on the coming rising edge
    if (edge_data_valid && edge_data_ready) begin
      assert (exp_q.size() != 0) else begin
        other_errors++;
        $display("edge_data %h appeared in %s with no result pending", edge_data, cur_name);
      end
      if (exp_q.size() != 0) begin
        expected_word = exp_q.pop_front();
        assert (edge_data == expected_word) else begin
          value_errors++;
          $display("error %s: expected %h actual %h", cur_name, expected_word, edge_data);
        end
      end
    end
    // one beat per address, in order, after a random gap
    m_axi_r.valid = 1'b0;
    if (r_wait > 0) begin
      r_wait--;
    end else if (ar_q.size() != 0) begin
      assert (m_axi_rready) else begin
        other_errors++;
        $display("read data offered in %s while m_axi_rready was low", cur_name);
      end
      beat_addr = ar_q.pop_front();
      m_axi_r.valid = 1'b1;
      m_axi_r.data = data_t'(beat_addr / addr_t'(word_bytes));
      m_axi_r.last = 1'b1;
      rnd_state = lcg_step(rnd_state);
      r_wait = int'(rnd_state[31:30]);
    end
    rnd_state = lcg_step(rnd_state);
    m_axi_arready = random_timing ? rnd_state[31] : 1'b1;
    // queued after the beat so data never leads its address
    if (m_axi_ar.valid && m_axi_arready) begin
      ar_q.push_back(m_axi_ar.addr);
      ar_count++;
    end
  end

  ////////////////////
  // sequencing tasks
  ////////////////////

  // which 0 watches full, which 1 watches stage_full
  task automatic wait_for_flag(input int which, input logic level);
    int cycles;
    cycles = 0;
    while (((which == 0) ? full : stage_full) != level && cycles < wait_limit) begin
      @(negedge aclk);
      cycles++;
    end
    assert (((which == 0) ? full : stage_full) == level) else begin
      other_errors++;
      $display("timeout in %s: %s did not go %0d", cur_name,
               (which == 0) ? "full" : "stage_full", level);
    end
  endtask

  task automatic start_test(input int code, input addr_t offset);
    @(posedge aclk);
    cur_code = code;
    cur_name = name_of_test(code);
    ready_hold = (code == 3 || code == 4);
    random_timing = (code == 5);
    n_expected = 0;
    ar_base = ar_count;
    @(negedge aclk);
    if (code != 1) begin
      ctrl_start = 1'b1;
      ctrl_addr_offset = offset;
      @(negedge aclk);
      ctrl_start = 1'b0;
    end
  endtask

  // kept addresses wait for room, dropped ones wait for full
  task automatic drive_edge(input addr_t addr, input data_t expd);
    if (cur_code != 1) begin
      wait_for_flag(0, expd == drop_mark);
    end
    edge_addr = addr;
    edge_addr_valid = 1'b1;
    if (cur_code != 1 && expd != drop_mark) begin
      exp_q.push_back(expd);
      n_expected++;
    end
    @(negedge aclk);
    edge_addr_valid = 1'b0;
    // gap cycle lets the registered write reach the FIFO
    @(negedge aclk);
  endtask

  task automatic finish_test();
    int cycles;
    case (cur_code)
      1: begin
        repeat (idle_window) begin
          @(negedge aclk);
          assert (!m_axi_ar.valid && !edge_data_valid) else begin
            other_errors++;
            $display("AR request or edge_data seen before ctrl_start");
          end
        end
      end
      3: begin
        assert (full) else begin
          other_errors++;
          $display("full stayed low with the address FIFO at depth");
        end
        @(posedge aclk);
        assert (ar_count - ar_base <= max_outstanding) else begin
          value_errors++;
          $display("error %s: expected at most %0d AR transfers actual %0d", cur_name,
                   max_outstanding, ar_count - ar_base);
        end
        ready_hold = 1'b0;
      end
      4: begin
        wait_for_flag(1, 1'b1);
        assert (!full) else begin
          other_errors++;
          $display("full went high with only half the address FIFO in use");
        end
        @(posedge aclk);
        ready_hold = 1'b0;
      end
      default: ;
    endcase
    // all results out, then both warnings must fall
    cycles = 0;
    while ((exp_q.size() != 0 || edge_data_valid) && cycles < wait_limit) begin
      @(negedge aclk);
      cycles++;
    end
    assert (exp_q.size() == 0) else begin
      other_errors++;
      $display("timeout in %s: %0d results never arrived", cur_name, exp_q.size());
      exp_q.delete();
    end
    wait_for_flag(0, 1'b0);
    wait_for_flag(1, 1'b0);
    @(posedge aclk);
    assert (ar_count - ar_base == n_expected) else begin
      value_errors++;
      $display("error %s: expected %0d AR transfers actual %0d", cur_name, n_expected,
               ar_count - ar_base);
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    int row;
    int code;
    int sva_fails;
    areset = 1'b1;
    ctrl_start = 1'b0;
    ctrl_addr_offset = '0;
    edge_addr = '0;
    edge_addr_valid = 1'b0;
    cur_code = 0;
    cur_name = "reset";
    foreach (golden[i]) begin
      golden[i] = '0;
    end
    $readmemh("sim/hbm_read_golden.txt", golden);
    repeat (16) @(posedge aclk);
    @(negedge aclk);
    // read data is refused while the controller is held in reset
    assert (!m_axi_rready) else begin
      other_errors++;
      $display("m_axi_rready was high while areset was held");
    end
    areset = 1'b0;
    row = 0;
    // a zero test code ends the table
    while (row < max_rows && golden[4*row] != 0) begin
      code = int'(golden[4*row]);
      if (code != cur_code) begin
        if (cur_code != 0) begin
          finish_test();
        end
        start_test(code, golden[4*row+1]);
      end
      drive_edge(golden[4*row+2], golden[4*row+3]);
      row++;
    end
    if (cur_code != 0) begin
      finish_test();
    end
    assert (row > 0) else begin
      other_errors++;
      $display("no stimulus rows read from sim/hbm_read_golden.txt");
    end
    sva_fails = uut.u_read_addr_issuer.u_sva.fail_count;
    $display("%0d value errors, %0d other failures, %0d assertion failures",
             value_errors, other_errors, sva_fails);
    if (value_errors + other_errors + sva_fails == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- hbm_read.f
src/hbm_read_pkg.sv
src/sync_fifo.sv
src/edge_request_stage.sv
src/read_addr_issuer.sv
src/hbm_read_top.sv
sim/hbm_read_sva.sv
sim/tb_hbm_read.sv

//--- Makefile
SIM      = verilator
TOP      = tb_hbm_read
FILELIST = hbm_read.f
FLAGS    = --binary --timing --assert -j 0
OBJ_DIR  = obj_dir
RUN_ARGS = +verilator+error+limit+100
PASS_MSG = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | \
		awk -v msg="$(PASS_MSG)" '{ print } $$0 == msg { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

//--- sim/hbm_read_golden.txt
// columns: test code, ctrl offset, edge address, expected edge_data (all hex)
// expected ffffffff marks an address that is dropped and returns nothing
1 00000000 00000000 ffffffff
1 00000000 00000004 ffffffff
2 00010003 00000000 00004000
2 00010003 00000010 00004004
2 00010003 00000ff8 000043fe
3 00020006 00000000 00008001
3 00020006 00000004 00008002
3 00020006 00000008 00008003
3 00020006 0000000c 00008004
3 00020006 00000010 00008005
3 00020006 00000014 00008006
3 00020006 00000018 00008007
3 00020006 0000001c 00008008
3 00020006 00000020 ffffffff
3 00020006 00000024 ffffffff
4 00030001 00000040 0000c010
4 00030001 00000080 0000c020
4 00030001 000000c0 0000c030
4 00030001 00000100 0000c040
4 00030001 00000140 0000c050
4 00030001 00000180 0000c060
5 00040002 00001000 00010400
5 00040002 00002004 00010801
5 00040002 00003008 00010c02
5 00040002 0000400c 00011003
5 00040002 00005010 00011404
5 00040002 00006014 00011805
